// File: cache/vcache_blocking_core.sv
// Blocking direct-mapped write-back cache core: tag, dirty and data
// arrays, hit service and the evict/fill miss FSM on the DMA port
`default_nettype none

module vcache_blocking_core #(
  parameter int addr_width_p          = 12,
  parameter int sets_p                = 16,
  parameter int block_size_in_words_p = 4
) (
  input  wire                                   clk_i,
  input  wire                                   arst_n_i,

  input  wire                                   cache_v_i,
  input  vcache_mem_pkg::cache_op_e             cache_op_i,
  input  wire  [addr_width_p-1:0]               cache_addr_i,
  input  wire  [vcache_mem_pkg::mask_width-1:0] cache_mask_i,
  input  wire  [vcache_mem_pkg::data_width-1:0] cache_wdata_i,
  output logic                                  cache_ready_o,

  output logic                                  rsp_v_o,
  output logic [vcache_mem_pkg::data_width-1:0] rsp_data_o,
  input  wire                                   rsp_yumi_i,

  output logic                                  dma_pkt_v_o,
  output logic                                  dma_pkt_write_o,
  output logic [addr_width_p-1:0]               dma_pkt_addr_o,
  input  wire                                   dma_pkt_yumi_i,

  input  wire  [vcache_mem_pkg::data_width-1:0] dma_data_i,
  input  wire                                   dma_data_v_i,
  output logic                                  dma_data_ready_o,

  output logic [vcache_mem_pkg::data_width-1:0] dma_data_o,
  output logic                                  dma_data_v_o,
  input  wire                                   dma_data_yumi_i
);

  localparam int offset_width_lp = $clog2(block_size_in_words_p);
  localparam int index_width_lp  = $clog2(sets_p);
  localparam int tag_width_lp    = addr_width_p - index_width_lp - offset_width_lp;
  localparam int data_width_lp   = vcache_mem_pkg::data_width;
  localparam int mask_width_lp   = vcache_mem_pkg::mask_width;

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_WB_PKT    = 3'd1;
  localparam logic [2:0] S_WB_DATA   = 3'd2;
  localparam logic [2:0] S_FILL_PKT  = 3'd3;
  localparam logic [2:0] S_FILL_DATA = 3'd4;
  localparam logic [2:0] S_REPLAY    = 3'd5;

  logic [2:0]                 state_r;
  logic [offset_width_lp-1:0] cnt_r;
  logic                       cnt_last;

  logic [sets_p-1:0]          valid_r;
  logic [sets_p-1:0]          dirty_r;
  logic [tag_width_lp-1:0]    tag_r  [sets_p];
  logic [data_width_lp-1:0]   data_r [sets_p*block_size_in_words_p];

  // Operation under service while a miss is in progress
  vcache_mem_pkg::cache_op_e  op_q;
  logic [addr_width_p-1:0]    addr_q;
  logic [mask_width_lp-1:0]   mask_q;
  logic [data_width_lp-1:0]   wdata_q;

  vcache_mem_pkg::cache_op_e  sel_op;
  logic [addr_width_p-1:0]    sel_addr;
  logic [mask_width_lp-1:0]   sel_mask;
  logic [data_width_lp-1:0]   sel_wdata;
  logic [tag_width_lp-1:0]    sel_tag;
  logic [index_width_lp-1:0]  sel_idx;
  logic [offset_width_lp-1:0] sel_off;
  logic                       sel_store;
  logic                       hit;
  logic                       accept;
  logic                       serve;
  logic [data_width_lp-1:0]   rd_word;
  logic [data_width_lp-1:0]   merged;

  // Idle looks at the incoming operation, miss states at the held one
  assign sel_op    = (state_r == S_IDLE) ? cache_op_i    : op_q;
  assign sel_addr  = (state_r == S_IDLE) ? cache_addr_i  : addr_q;
  assign sel_mask  = (state_r == S_IDLE) ? cache_mask_i  : mask_q;
  assign sel_wdata = (state_r == S_IDLE) ? cache_wdata_i : wdata_q;

  assign sel_tag   = sel_addr[addr_width_p-1 -: tag_width_lp];
  assign sel_idx   = sel_addr[offset_width_lp +: index_width_lp];
  assign sel_off   = sel_addr[offset_width_lp-1:0];
  assign sel_store = (sel_op == vcache_mem_pkg::CACHE_OP_SM);

  assign hit      = valid_r[sel_idx] & (tag_r[sel_idx] == sel_tag);
  assign cache_ready_o = (state_r == S_IDLE) & (~rsp_v_o | rsp_yumi_i);
  assign accept   = cache_v_i & cache_ready_o;
  assign serve    = (accept & hit) | (state_r == S_REPLAY);
  assign rd_word  = data_r[{sel_idx, sel_off}];
  assign cnt_last = (cnt_r == offset_width_lp'(block_size_in_words_p - 1));

  always_comb begin
    for (int b = 0; b < mask_width_lp; b++) begin
      merged[8*b +: 8] = sel_mask[b] ? sel_wdata[8*b +: 8] : rd_word[8*b +: 8];
    end
  end

  assign dma_pkt_v_o      = (state_r == S_WB_PKT) | (state_r == S_FILL_PKT);
  assign dma_pkt_write_o  = (state_r == S_WB_PKT) ? vcache_mem_pkg::dma_pkt_write
                                                  : vcache_mem_pkg::dma_pkt_read;
  // Evictions go to the resident tag, fills to the requested one
  assign dma_pkt_addr_o   = (state_r == S_WB_PKT)
                          ? {tag_r[sel_idx], sel_idx, {offset_width_lp{1'b0}}}
                          : {sel_tag, sel_idx, {offset_width_lp{1'b0}}};
  assign dma_data_v_o     = (state_r == S_WB_DATA);
  assign dma_data_o       = data_r[{sel_idx, cnt_r}];
  assign dma_data_ready_o = (state_r == S_FILL_DATA);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= S_IDLE;
      cnt_r   <= '0;
      valid_r <= '0;
      dirty_r <= '0;
      rsp_v_o <= 1'b0;
    end else begin
      if (rsp_yumi_i) begin
        rsp_v_o <= 1'b0;
      end
      if (serve) begin
        rsp_v_o <= 1'b1;
        if (sel_store) begin
          dirty_r[sel_idx] <= 1'b1;
        end
      end
      case (state_r)
        S_IDLE: begin
          if (accept && !hit) begin
            cnt_r   <= '0;
            state_r <= (valid_r[sel_idx] && dirty_r[sel_idx]) ? S_WB_PKT : S_FILL_PKT;
          end
        end
        S_WB_PKT: begin
          if (dma_pkt_yumi_i) begin
            state_r <= S_WB_DATA;
          end
        end
        S_WB_DATA: begin
          if (dma_data_yumi_i) begin
            cnt_r <= cnt_last ? '0 : cnt_r + 1'b1;
            if (cnt_last) begin
              state_r <= S_FILL_PKT;
            end
          end
        end
        S_FILL_PKT: begin
          if (dma_pkt_yumi_i) begin
            state_r <= S_FILL_DATA;
          end
        end
        S_FILL_DATA: begin
          if (dma_data_v_i) begin
            cnt_r <= cnt_last ? '0 : cnt_r + 1'b1;
            if (cnt_last) begin
              valid_r[sel_idx] <= 1'b1;
              dirty_r[sel_idx] <= 1'b0;
              state_r          <= S_REPLAY;
            end
          end
        end
        default: begin
          state_r <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= cache_op_i;
      addr_q  <= cache_addr_i;
      mask_q  <= cache_mask_i;
      wdata_q <= cache_wdata_i;
    end
    if (state_r == S_FILL_DATA && dma_data_v_i) begin
      data_r[{sel_idx, cnt_r}] <= dma_data_i;
      if (cnt_last) begin
        tag_r[sel_idx] <= sel_tag;
      end
    end
    if (serve) begin
      if (sel_store) begin
        data_r[{sel_idx, sel_off}] <= merged;
      end
      // Store acknowledge carries zero
      rsp_data_o <= sel_store ? '0 : rd_word;
    end
  end

endmodule

`default_nettype wire

// File: common/vcache_link_pkg.sv
// Network-side definitions: coordinate and register id widths,
// request opcodes, response types and the request payload union
`default_nettype none

package vcache_link_pkg;

  parameter int x_cord_width  = 4;
  parameter int y_cord_width  = 4;
  parameter int reg_id_width  = 5;
  parameter int payload_width = 32;

  typedef enum logic [1:0] {
    LINK_OP_LOAD  = 2'b00,
    LINK_OP_STORE = 2'b01
  } link_op_e;

  typedef enum logic {
    LINK_RSP_LOAD_DATA = 1'b0,
    LINK_RSP_STORE_ACK = 1'b1
  } link_rsp_type_e;

  // Load view of the payload, reg id in the low bits
  typedef struct packed {
    logic [payload_width-reg_id_width-1:0] zero;
    logic [reg_id_width-1:0]               reg_id;
  } link_load_info_s;

  // Stores carry data here, loads carry the destination register
  typedef union packed {
    logic [payload_width-1:0] store_data;
    link_load_info_s          load_info;
  } link_payload_u;

endpackage

`default_nettype wire

// File: common/vcache_mem_pkg.sv
// Memory-side definitions: word and mask widths, cache opcodes
// and the DMA packet command encoding
`default_nettype none

package vcache_mem_pkg;

  parameter int data_width = 32;
  parameter int mask_width = data_width / 8;

  typedef enum logic {
    CACHE_OP_LW = 1'b0,
    CACHE_OP_SM = 1'b1
  } cache_op_e;

  // DMA packet write-not-read field
  parameter logic dma_pkt_read  = 1'b0;
  parameter logic dma_pkt_write = 1'b1;

endpackage

`default_nettype wire

// File: hdl/vcache_top.sv
// Cache endpoint top: request decode, blocking cache core and
// response formatting on a mesh link, with a DMA port to memory
`default_nettype none

module vcache_top #(
  parameter int addr_width_p          = 12,
  parameter int sets_p                = 16,
  parameter int block_size_in_words_p = 4
) (
  input  wire                                         clk_i,
  input  wire                                         arst_n_i,

  input  wire                                         link_req_v_i,
  output logic                                        link_req_ready_o,
  input  vcache_link_pkg::link_op_e                   link_req_op_i,
  input  wire  [addr_width_p-1:0]                     link_req_addr_i,
  input  wire  [vcache_mem_pkg::mask_width-1:0]       link_req_mask_i,
  input  wire  [vcache_link_pkg::x_cord_width-1:0]    link_req_src_x_i,
  input  wire  [vcache_link_pkg::y_cord_width-1:0]    link_req_src_y_i,
  input  vcache_link_pkg::link_payload_u              link_req_payload_i,

  output logic                                        link_rsp_v_o,
  output vcache_link_pkg::link_rsp_type_e             link_rsp_type_o,
  output logic [vcache_mem_pkg::data_width-1:0]       link_rsp_data_o,
  output logic [vcache_link_pkg::reg_id_width-1:0]    link_rsp_reg_id_o,
  output logic [vcache_link_pkg::x_cord_width-1:0]    link_rsp_dest_x_o,
  output logic [vcache_link_pkg::y_cord_width-1:0]    link_rsp_dest_y_o,
  input  wire                                         link_rsp_yumi_i,

  output logic                                        dma_pkt_v_o,
  output logic                                        dma_pkt_write_o,
  output logic [addr_width_p-1:0]                     dma_pkt_addr_o,
  input  wire                                         dma_pkt_yumi_i,

  input  wire  [vcache_mem_pkg::data_width-1:0]       dma_data_i,
  input  wire                                         dma_data_v_i,
  output logic                                        dma_data_ready_o,

  output logic [vcache_mem_pkg::data_width-1:0]       dma_data_o,
  output logic                                        dma_data_v_o,
  input  wire                                         dma_data_yumi_i
);

  logic                                     cache_v;
  vcache_mem_pkg::cache_op_e                cache_op;
  logic [addr_width_p-1:0]                  cache_addr;
  logic [vcache_mem_pkg::mask_width-1:0]    cache_mask;
  logic [vcache_mem_pkg::data_width-1:0]    cache_wdata;
  logic                                     cache_ready;

  logic                                     info_push;
  logic [vcache_link_pkg::x_cord_width-1:0] info_src_x;
  logic [vcache_link_pkg::y_cord_width-1:0] info_src_y;
  logic [vcache_link_pkg::reg_id_width-1:0] info_reg_id;
  vcache_link_pkg::link_rsp_type_e          info_type;
  logic                                     info_full;

  logic                                     rsp_v;
  logic [vcache_mem_pkg::data_width-1:0]    rsp_data;
  logic                                     rsp_yumi;

  link_request_decode #(
    .addr_width_p (addr_width_p)
  ) decode_i (
    .clk_i, .arst_n_i,
    .link_req_v_i, .link_req_ready_o, .link_req_op_i, .link_req_addr_i,
    .link_req_mask_i, .link_req_src_x_i, .link_req_src_y_i, .link_req_payload_i,
    .cache_v_o     (cache_v),
    .cache_op_o    (cache_op),
    .cache_addr_o  (cache_addr),
    .cache_mask_o  (cache_mask),
    .cache_wdata_o (cache_wdata),
    .cache_ready_i (cache_ready),
    .info_push_o   (info_push),
    .info_src_x_o  (info_src_x),
    .info_src_y_o  (info_src_y),
    .info_reg_id_o (info_reg_id),
    .info_type_o   (info_type),
    .info_full_i   (info_full)
  );

  vcache_blocking_core #(
    .addr_width_p          (addr_width_p),
    .sets_p                (sets_p),
    .block_size_in_words_p (block_size_in_words_p)
  ) core_i (
    .clk_i, .arst_n_i,
    .cache_v_i     (cache_v),
    .cache_op_i    (cache_op),
    .cache_addr_i  (cache_addr),
    .cache_mask_i  (cache_mask),
    .cache_wdata_i (cache_wdata),
    .cache_ready_o (cache_ready),
    .rsp_v_o       (rsp_v),
    .rsp_data_o    (rsp_data),
    .rsp_yumi_i    (rsp_yumi),
    .dma_pkt_v_o, .dma_pkt_write_o, .dma_pkt_addr_o, .dma_pkt_yumi_i,
    .dma_data_i, .dma_data_v_i, .dma_data_ready_o,
    .dma_data_o, .dma_data_v_o, .dma_data_yumi_i
  );

  link_response_format result_i (
    .clk_i, .arst_n_i,
    .info_push_i   (info_push),
    .info_src_x_i  (info_src_x),
    .info_src_y_i  (info_src_y),
    .info_reg_id_i (info_reg_id),
    .info_type_i   (info_type),
    .info_full_o   (info_full),
    .rsp_v_i       (rsp_v),
    .rsp_data_i    (rsp_data),
    .rsp_yumi_o    (rsp_yumi),
    .link_rsp_v_o, .link_rsp_type_o, .link_rsp_data_o, .link_rsp_reg_id_o,
    .link_rsp_dest_x_o, .link_rsp_dest_y_o, .link_rsp_yumi_i
  );

endmodule

`default_nettype wire

// File: link_adapter/link_request_decode.sv
// Request decode stage: network opcode and payload decode,
// one-entry holding register toward the cache core
`default_nettype none

module link_request_decode #(
  parameter int addr_width_p = 12
) (
  input  wire                                      clk_i,
  input  wire                                      arst_n_i,

  input  wire                                      link_req_v_i,
  output logic                                     link_req_ready_o,
  input  vcache_link_pkg::link_op_e                link_req_op_i,
  input  wire  [addr_width_p-1:0]                  link_req_addr_i,
  input  wire  [vcache_mem_pkg::mask_width-1:0]    link_req_mask_i,
  input  wire  [vcache_link_pkg::x_cord_width-1:0] link_req_src_x_i,
  input  wire  [vcache_link_pkg::y_cord_width-1:0] link_req_src_y_i,
  input  vcache_link_pkg::link_payload_u           link_req_payload_i,

  output logic                                     cache_v_o,
  output vcache_mem_pkg::cache_op_e                cache_op_o,
  output logic [addr_width_p-1:0]                  cache_addr_o,
  output logic [vcache_mem_pkg::mask_width-1:0]    cache_mask_o,
  output logic [vcache_mem_pkg::data_width-1:0]    cache_wdata_o,
  input  wire                                      cache_ready_i,

  output logic                                     info_push_o,
  output logic [vcache_link_pkg::x_cord_width-1:0] info_src_x_o,
  output logic [vcache_link_pkg::y_cord_width-1:0] info_src_y_o,
  output logic [vcache_link_pkg::reg_id_width-1:0] info_reg_id_o,
  output vcache_link_pkg::link_rsp_type_e          info_type_o,
  input  wire                                      info_full_i
);

  logic is_store;
  logic accept;

  assign is_store = (link_req_op_i == vcache_link_pkg::LINK_OP_STORE);

  // Holding register frees up in the same cycle the core takes it
  assign link_req_ready_o = (~cache_v_o | cache_ready_i) & ~info_full_i;
  assign accept           = link_req_v_i & link_req_ready_o;

  // Return information goes straight into the result FIFO
  assign info_push_o   = accept;
  assign info_src_x_o  = link_req_src_x_i;
  assign info_src_y_o  = link_req_src_y_i;
  assign info_type_o   = is_store ? vcache_link_pkg::LINK_RSP_STORE_ACK
                                  : vcache_link_pkg::LINK_RSP_LOAD_DATA;
  // Stores have no destination register
  assign info_reg_id_o = is_store ? '0 : link_req_payload_i.load_info.reg_id;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cache_v_o <= 1'b0;
    end else if (accept) begin
      cache_v_o <= 1'b1;
    end else if (cache_ready_i) begin
      cache_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cache_op_o    <= is_store ? vcache_mem_pkg::CACHE_OP_SM : vcache_mem_pkg::CACHE_OP_LW;
      cache_addr_o  <= link_req_addr_i;
      cache_mask_o  <= link_req_mask_i;
      cache_wdata_o <= is_store ? link_req_payload_i.store_data : '0;
    end
  end

endmodule

`default_nettype wire

// File: link_adapter/link_response_format.sv
// Response stage: two-entry return-information FIFO paired
// with cache answers to build in-order network responses
`default_nettype none

module link_response_format (
  input  wire                                      clk_i,
  input  wire                                      arst_n_i,

  input  wire                                      info_push_i,
  input  wire  [vcache_link_pkg::x_cord_width-1:0] info_src_x_i,
  input  wire  [vcache_link_pkg::y_cord_width-1:0] info_src_y_i,
  input  wire  [vcache_link_pkg::reg_id_width-1:0] info_reg_id_i,
  input  vcache_link_pkg::link_rsp_type_e          info_type_i,
  output logic                                     info_full_o,

  input  wire                                      rsp_v_i,
  input  wire  [vcache_mem_pkg::data_width-1:0]    rsp_data_i,
  output logic                                     rsp_yumi_o,

  output logic                                     link_rsp_v_o,
  output vcache_link_pkg::link_rsp_type_e          link_rsp_type_o,
  output logic [vcache_mem_pkg::data_width-1:0]    link_rsp_data_o,
  output logic [vcache_link_pkg::reg_id_width-1:0] link_rsp_reg_id_o,
  output logic [vcache_link_pkg::x_cord_width-1:0] link_rsp_dest_x_o,
  output logic [vcache_link_pkg::y_cord_width-1:0] link_rsp_dest_y_o,
  input  wire                                      link_rsp_yumi_i
);

  logic [vcache_link_pkg::x_cord_width-1:0] src_x_r  [2];
  logic [vcache_link_pkg::y_cord_width-1:0] src_y_r  [2];
  logic [vcache_link_pkg::reg_id_width-1:0] reg_id_r [2];
  vcache_link_pkg::link_rsp_type_e          type_r   [2];
  logic                                     wr_ptr_r;
  logic                                     rd_ptr_r;
  logic [1:0]                               count_r;
  logic                                     pop;

  assign info_full_o = (count_r == 2'd2);
  assign pop         = link_rsp_yumi_i;

  // A cache answer always has its entry at the FIFO head
  assign link_rsp_v_o      = rsp_v_i & (count_r != 2'd0);
  assign rsp_yumi_o        = link_rsp_yumi_i;
  assign link_rsp_data_o   = rsp_data_i;
  assign link_rsp_type_o   = type_r[rd_ptr_r];
  assign link_rsp_reg_id_o = reg_id_r[rd_ptr_r];
  assign link_rsp_dest_x_o = src_x_r[rd_ptr_r];
  assign link_rsp_dest_y_o = src_y_r[rd_ptr_r];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (info_push_i) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      count_r <= count_r + 2'(info_push_i) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (info_push_i) begin
      src_x_r[wr_ptr_r]  <= info_src_x_i;
      src_y_r[wr_ptr_r]  <= info_src_y_i;
      reg_id_r[wr_ptr_r] <= info_reg_id_i;
      type_r[wr_ptr_r]   <= info_type_i;
    end
  end

endmodule

`default_nettype wire

// File: list.f
common/vcache_link_pkg.sv
common/vcache_mem_pkg.sv
link_adapter/link_request_decode.sv
link_adapter/link_response_format.sv
cache/vcache_blocking_core.sv
hdl/vcache_top.sv
verification/vcache_mem_model.sv
verification/vcache_tb.sv

// File: verification/vcache_mem_model.sv
// Memory model on the DMA port: block reads and writes
// with random handshake delays
`default_nettype none

module vcache_mem_model #(
  parameter int          addr_width_p          = 12,
  parameter int          block_size_in_words_p = 4,
  parameter logic [31:0] pattern_p             = 32'h0
) (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     dma_pkt_v_i,
  input  wire                     dma_pkt_write_i,
  input  wire  [addr_width_p-1:0] dma_pkt_addr_i,
  output logic                    dma_pkt_yumi_o,
  output logic [31:0]             dma_data_o,
  output logic                    dma_data_v_o,
  input  wire                     dma_data_ready_i,
  input  wire  [31:0]             dma_data_i,
  input  wire                     dma_data_v_i,
  output logic                    dma_data_yumi_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0]             mem [1 << addr_width_p];
  logic [31:0]             rng;
  logic                    go;
  logic                    wr_busy;
  logic                    rd_busy;
  logic [addr_width_p-1:0] base;
  int                      cnt;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    for (int i = 0; i < (1 << addr_width_p); i++) begin
      mem[i] = i ^ pattern_p;
    end
  end

  // One transfer at a time, each handshake gated by the random go bit
  assign dma_pkt_yumi_o  = dma_pkt_v_i & go & ~wr_busy & ~rd_busy;
  assign dma_data_yumi_o = dma_data_v_i & go & wr_busy;
  assign dma_data_v_o    = rd_busy & go;
  assign dma_data_o      = mem[base + cnt];

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rng     <= 32'd48;
      go      <= 1'b0;
      wr_busy <= 1'b0;
      rd_busy <= 1'b0;
      base    <= '0;
      cnt     <= 0;
    end else begin
      rng <= lcg_step(rng);
      go  <= (rng[17:16] != 2'b00);
      if (dma_pkt_yumi_o) begin
        base    <= dma_pkt_addr_i;
        cnt     <= 0;
        wr_busy <= dma_pkt_write_i;
        rd_busy <= ~dma_pkt_write_i;
      end
      if (dma_data_yumi_o) begin
        mem[base + cnt] <= dma_data_i;
      end
      if (dma_data_yumi_o || (dma_data_v_o && dma_data_ready_i)) begin
        cnt <= cnt + 1;
        if (cnt == block_size_in_words_p - 1) begin
          wr_busy <= 1'b0;
          rd_busy <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/vcache_tb.sv
// Cache endpoint testbench: directed and random requests,
// in-order scoreboard, response and write-back checks
`default_nettype none

module vcache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          addr_width_lp = 12;
  localparam int          block_lp      = 4;
  localparam logic [31:0] pattern_lp    = 32'h5a3c_96e1;
  localparam int          timeout_lp    = 1000;

  logic                                     clk_i = 1'b0;
  logic                                     arst_n_i;
  logic                                     link_req_v_i;
  logic                                     link_req_ready_o;
  vcache_link_pkg::link_op_e                link_req_op_i;
  logic [addr_width_lp-1:0]                 link_req_addr_i;
  logic [vcache_mem_pkg::mask_width-1:0]    link_req_mask_i;
  logic [vcache_link_pkg::x_cord_width-1:0] link_req_src_x_i;
  logic [vcache_link_pkg::y_cord_width-1:0] link_req_src_y_i;
  vcache_link_pkg::link_payload_u           link_req_payload_i;
  logic                                     link_rsp_v_o;
  vcache_link_pkg::link_rsp_type_e          link_rsp_type_o;
  logic [31:0]                              link_rsp_data_o;
  logic [vcache_link_pkg::reg_id_width-1:0] link_rsp_reg_id_o;
  logic [vcache_link_pkg::x_cord_width-1:0] link_rsp_dest_x_o;
  logic [vcache_link_pkg::y_cord_width-1:0] link_rsp_dest_y_o;
  logic                                     link_rsp_yumi_i;
  logic                                     dma_pkt_v_o;
  logic                                     dma_pkt_write_o;
  logic [addr_width_lp-1:0]                 dma_pkt_addr_o;
  logic                                     dma_pkt_yumi_i;
  logic [31:0]                              dma_data_i;
  logic                                     dma_data_v_i;
  logic                                     dma_data_ready_o;
  logic [31:0]                              dma_data_o;
  logic                                     dma_data_v_o;
  logic                                     dma_data_yumi_i;

  logic                     yumi_en;
  logic                     yumi_random;
  logic [31:0]              rng = 32'd48;
  logic [31:0]              yumi_rng = 32'd48;
  logic [31:0]              model [1 << addr_width_lp];
  logic [61:0]              req_q [$];
  int                       pending = 0;
  int                       cycle_cnt = 0;
  int                       acc_cycle = 0;
  int                       take_cycle = 0;
  logic [addr_width_lp-1:0] wb_addr = '0;
  int                       wb_cnt = 0;
  logic                     hold_v = 1'b0;
  logic [46:0]              hold_rsp = '0;
  logic [46:0]              rsp_bundle;

  vcache_top #(
    .addr_width_p          (addr_width_lp),
    .sets_p                (16),
    .block_size_in_words_p (block_lp)
  ) dut_i (.*);

  vcache_mem_model #(
    .addr_width_p          (addr_width_lp),
    .block_size_in_words_p (block_lp),
    .pattern_p             (pattern_lp)
  ) mem_i (
    .clk_i, .arst_n_i,
    .dma_pkt_v_i      (dma_pkt_v_o),
    .dma_pkt_write_i  (dma_pkt_write_o),
    .dma_pkt_addr_i   (dma_pkt_addr_o),
    .dma_pkt_yumi_o   (dma_pkt_yumi_i),
    .dma_data_o       (dma_data_i),
    .dma_data_v_o     (dma_data_v_i),
    .dma_data_ready_i (dma_data_ready_o),
    .dma_data_i       (dma_data_o),
    .dma_data_v_i     (dma_data_v_o),
    .dma_data_yumi_o  (dma_data_yumi_i)
  );

  always #10 clk_i = ~clk_i;

  // Yumi reaches the DUT only while a response is valid
  assign link_rsp_yumi_i = link_rsp_v_o & yumi_en;
  assign rsp_bundle = {link_rsp_v_o, link_rsp_type_o, link_rsp_data_o, link_rsp_reg_id_o,
                       link_rsp_dest_x_o, link_rsp_dest_y_o};

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] lcg_next();
    rng = lcg_step(rng);
    return {8'd0, rng[31:8]};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  mask);
    logic [31:0] result;
    for (int b = 0; b < 4; b++) begin
      result[8*b +: 8] = mask[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    assert (act_val === exp_val)
    else abort_run($sformatf("** Error at %0d ns: %s expected %0h, got %0h",
                             $time, name, exp_val, act_val));
  endtask

  task automatic send_req(input logic is_store, input logic [addr_width_lp-1:0] addr,
                          input logic [3:0] mask, input logic [31:0] data,
                          input logic [4:0] reg_id);
    int          t;
    logic [31:0] r;
    t = 0;
    r = lcg_next();
    if (is_store) begin
      link_req_op_i <= vcache_link_pkg::LINK_OP_STORE;
    end else begin
      link_req_op_i <= vcache_link_pkg::LINK_OP_LOAD;
    end
    link_req_v_i       <= 1'b1;
    link_req_addr_i    <= addr;
    link_req_mask_i    <= mask;
    link_req_payload_i <= is_store ? data : {27'd0, reg_id};
    link_req_src_x_i   <= r[3:0];
    link_req_src_y_i   <= r[7:4];
    @(posedge clk_i);
    while (!link_req_ready_o) begin
      t++;
      if (t > timeout_lp) begin
        abort_run("Timeout: the DUT did not accept a request");
      end else begin
        @(posedge clk_i);
      end
    end
    link_req_v_i <= 1'b0;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    @(posedge clk_i);
    while (pending != 0) begin
      t++;
      if (t > timeout_lp) begin
        abort_run("Timeout: outstanding requests got no response");
      end else begin
        @(posedge clk_i);
      end
    end
  endtask

  // Random yumi stretches come from a separate sequence
  always @(posedge clk_i) begin
    if (yumi_random) begin
      yumi_rng <= lcg_step(yumi_rng);
      yumi_en  <= (yumi_rng[23:8] % 3 != 0);
    end else begin
      yumi_en <= 1'b1;
    end
  end

  // Model is updated as responses leave, so it always matches the cache view
  always @(posedge clk_i) begin : scoreboard
    logic                     h_st;
    logic [addr_width_lp-1:0] h_addr;
    logic [3:0]               h_mask;
    logic [31:0]              h_wdata;
    logic [3:0]               h_x;
    logic [3:0]               h_y;
    logic [4:0]               h_reg;
    logic                     st;
    logic [31:0]              payload;
    if (arst_n_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (hold_v) begin
        check_field("link_rsp_* while stalled", hold_rsp, rsp_bundle);
      end
      if (link_rsp_v_o && req_q.size() == 0) begin
        abort_run("A response arrived with no request outstanding");
      end else if (link_rsp_v_o) begin
        {h_st, h_addr, h_mask, h_wdata, h_x, h_y, h_reg} = req_q[0];
        check_field("link_rsp_type_o",
                    h_st ? vcache_link_pkg::LINK_RSP_STORE_ACK
                         : vcache_link_pkg::LINK_RSP_LOAD_DATA,
                    link_rsp_type_o);
        check_field("link_rsp_data_o", h_st ? 32'd0 : model[h_addr], link_rsp_data_o);
        check_field("link_rsp_reg_id_o", h_reg, link_rsp_reg_id_o);
        check_field("link_rsp_dest_x_o", h_x, link_rsp_dest_x_o);
        check_field("link_rsp_dest_y_o", h_y, link_rsp_dest_y_o);
        if (link_rsp_yumi_i) begin
          void'(req_q.pop_front());
          if (h_st) begin
            model[h_addr] = merge_bytes(model[h_addr], h_wdata, h_mask);
          end
          take_cycle <= cycle_cnt;
        end
      end
      if (dma_pkt_v_o && dma_pkt_yumi_i && dma_pkt_write_o) begin
        wb_addr <= dma_pkt_addr_o;
        wb_cnt  <= 0;
      end
      if (dma_data_v_o && dma_data_yumi_i) begin
        check_field("dma_data_o", model[wb_addr + wb_cnt], dma_data_o);
        wb_cnt <= wb_cnt + 1;
      end
      if (link_req_v_i && link_req_ready_o) begin
        st      = (link_req_op_i == vcache_link_pkg::LINK_OP_STORE);
        payload = link_req_payload_i;
        // Loads put the reg id in the low payload bits, stores carry none
        req_q.push_back({st, link_req_addr_i, link_req_mask_i, payload,
                         link_req_src_x_i, link_req_src_y_i,
                         st ? 5'd0 : payload[4:0]});
        acc_cycle <= cycle_cnt;
      end
      pending  <= req_q.size();
      hold_v   <= link_rsp_v_o & ~link_rsp_yumi_i;
      hold_rsp <= rsp_bundle;
    end
  end

  initial begin
    logic [31:0] r;
    for (int i = 0; i < (1 << addr_width_lp); i++) begin
      model[i] = i ^ pattern_lp;
    end
    arst_n_i           = 1'b0;
    link_req_v_i       = 1'b0;
    link_req_op_i      = vcache_link_pkg::LINK_OP_LOAD;
    link_req_addr_i    = '0;
    link_req_mask_i    = '0;
    link_req_src_x_i   = '0;
    link_req_src_y_i   = '0;
    link_req_payload_i = '0;
    yumi_en            = 1'b1;
    yumi_random        = 1'b0;
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    check_field("link_rsp_v_o", 0, link_rsp_v_o);
    check_field("dma_pkt_v_o", 0, dma_pkt_v_o);
    check_field("dma_data_v_o", 0, dma_data_v_o);
    check_field("dma_data_ready_o", 0, dma_data_ready_o);
    check_field("link_req_ready_o", 1, link_req_ready_o);
    // Untouched word, masked store, reload
    send_req(1'b0, 12'h123, 4'h0, 32'd0, 5'd7);
    send_req(1'b1, 12'h123, 4'b0101, lcg_next(), 5'd0);
    send_req(1'b0, 12'h123, 4'h0, 32'd0, 5'd19);
    // Same index, new tag, so the dirty line goes back to memory
    send_req(1'b1, 12'h0a4, 4'hf, lcg_next(), 5'd0);
    send_req(1'b1, 12'h0e4, 4'h3, lcg_next(), 5'd0);
    wait_idle();
    check_field("dma_pkt_addr_o", 12'h0a4, wb_addr);
    send_req(1'b0, 12'h0a4, 4'h0, 32'd0, 5'd11);
    send_req(1'b0, 12'h0e4, 4'h0, 32'd0, 5'd12);
    wait_idle();
    send_req(1'b0, 12'h0e4, 4'h0, 32'd0, 5'd3);
    wait_idle();
    @(posedge clk_i);
    check_field("hit response latency in cycles", 2, take_cycle - acc_cycle);
    yumi_random <= 1'b1;
    repeat (80) begin
      r = lcg_next();
      send_req(r[0], {4'd0, r[8:1]}, r[12:9], lcg_next(), r[17:13]);
    end
    yumi_random <= 1'b0;
    wait_idle();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
